// File: common/snake_display_pkg.sv
// --------------------------------------------------------------------------
// snake display shared definitions
// tile grid geometry, tile kind codes and RGB565 palette
// host register map, scan counter widths
// tile write and scan position structs
// --------------------------------------------------------------------------
`default_nettype none

package snake_display_pkg;

  // tile grid, 20 x 15 tiles of 32 x 32 pixels
  localparam int GRID_COLS  = 20;
  localparam int GRID_ROWS  = 15;
  localparam int COL_W      = 5;
  localparam int ROW_W      = 4;
  localparam int TILE_SHIFT = 5;

  // tile kinds, codes 5..7 draw as empty
  localparam int KIND_W = 3;
  localparam logic [KIND_W-1:0] KIND_EMPTY = 3'd0;
  localparam logic [KIND_W-1:0] KIND_WALL  = 3'd1;
  localparam logic [KIND_W-1:0] KIND_APPLE = 3'd2;
  localparam logic [KIND_W-1:0] KIND_HEAD  = 3'd3;
  localparam logic [KIND_W-1:0] KIND_BODY  = 3'd4;

  // palette in RGB565
  localparam logic [15:0] PAL_EMPTY = 16'h0000;  // black
  localparam logic [15:0] PAL_WALL  = 16'h8410;  // grey
  localparam logic [15:0] PAL_APPLE = 16'hf800;  // red
  localparam logic [15:0] PAL_HEAD  = 16'hffe0;  // yellow
  localparam logic [15:0] PAL_BODY  = 16'h07e0;  // green

  // host register addresses
  localparam logic [2:0] REG_COL  = 3'd0;
  localparam logic [2:0] REG_ROW  = 3'd1;
  localparam logic [2:0] REG_KIND = 3'd2;

  // scan counter widths
  localparam int HCOUNT_W = 11;
  localparam int VCOUNT_W = 10;

  // one tile write, valid for a single cycle
  typedef struct packed {
    logic              valid;
    logic [COL_W-1:0]  col;
    logic [ROW_W-1:0]  row;
    logic [KIND_W-1:0] kind;
  } tile_write_t;

  // scan position plus decoded sync and active flags
  typedef struct packed {
    logic [HCOUNT_W-1:0] hcount;
    logic [VCOUNT_W-1:0] vcount;
    logic                active;
    logic                hs;
    logic                vs;
    logic                pix_clk;
  } scan_pos_t;

endpackage

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the snake display testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module snake_display_tb \
  -f snake_display.f -o snake_display_sim

output=$(./obj_dir/snake_display_sim)
echo "$output"

if echo "$output" | grep -qx "No errors"; then
  exit 0
else
  exit 1
fi

// File: snake_display.f
common/snake_display_pkg.sv
vga/vga_timing.sv
source/host_regs.sv
tiles/tile_map.sv
tiles/tile_renderer.sv
source/snake_display.sv
tests/tb_clock.sv
tests/snake_display_tb.sv

// File: source/host_regs.sv
// --------------------------------------------------------------------------
// host register port
// column and row registers, address decode
// range-checked one-cycle tile write on each kind write
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module host_regs (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             chipselect,
  input  logic                             write,
  input  logic [2:0]                       address,
  input  logic [7:0]                       writedata,
  output snake_display_pkg::tile_write_t   tile_wr
);

  import snake_display_pkg::*;

  logic              wr_en;
  logic [COL_W-1:0]  col_q;
  logic [ROW_W-1:0]  row_q;
  logic              in_range;
  logic              wr_valid;
  logic [COL_W-1:0]  wr_col;
  logic [ROW_W-1:0]  wr_row;
  logic [KIND_W-1:0] wr_kind;

  // single-cycle bus write, no wait states
  assign wr_en = chipselect && write;

  // stored coordinates must land inside the grid
  assign in_range = (col_q < COL_W'(GRID_COLS)) && (row_q < ROW_W'(GRID_ROWS));

  // coordinate registers, low bits of the bus word
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      col_q <= '0;
      row_q <= '0;
    end else if (wr_en) begin
      if (address == REG_COL) begin
        col_q <= writedata[COL_W-1:0];
      end
      if (address == REG_ROW) begin
        row_q <= writedata[ROW_W-1:0];
      end
    end
  end

  // tile write strobe, one cycle after the kind write
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_valid <= 1'b0;
    end else begin
      wr_valid <= wr_en && (address == REG_KIND) && in_range;
    end
  end

  // payload follows the strobe
  always_ff @(posedge clk) begin
    wr_col  <= col_q;
    wr_row  <= row_q;
    wr_kind <= writedata[KIND_W-1:0];
  end

  assign tile_wr = '{valid: wr_valid, col: wr_col, row: wr_row, kind: wr_kind};

  a_wr_in_grid: assert property (@(posedge clk) disable iff (reset)
    tile_wr.valid |-> (tile_wr.col < COL_W'(GRID_COLS)) && (tile_wr.row < ROW_W'(GRID_ROWS)));

endmodule

`default_nettype wire

// File: source/snake_display.sv
// --------------------------------------------------------------------------
// snake tile display top level
// scan timing, host registers, tile map and renderer
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module snake_display #(
  parameter int H_ACTIVE = 1280,
  parameter int H_FRONT  = 32,
  parameter int H_SYNC   = 192,
  parameter int H_BACK   = 96,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] writedata,
  input  logic       write,
  input  logic       chipselect,
  input  logic [2:0] address,
  output logic [7:0] vga_r,
  output logic [7:0] vga_g,
  output logic [7:0] vga_b,
  output logic       vga_clk,
  output logic       vga_hs,
  output logic       vga_vs,
  output logic       vga_blank_n
);

  import snake_display_pkg::*;

  scan_pos_t         scan;
  tile_write_t       tile_wr;
  logic [COL_W-1:0]  rd_col;
  logic [ROW_W-1:0]  rd_row;
  logic [KIND_W-1:0] rd_kind;

  // scan position generator
  vga_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) u_timing (
    .clk   (clk),
    .reset (reset),
    .scan  (scan)
  );

  // host side
  host_regs u_regs (
    .clk        (clk),
    .reset      (reset),
    .chipselect (chipselect),
    .write      (write),
    .address    (address),
    .writedata  (writedata),
    .tile_wr    (tile_wr)
  );

  tile_map u_map (
    .clk     (clk),
    .reset   (reset),
    .tile_wr (tile_wr),
    .rd_col  (rd_col),
    .rd_row  (rd_row),
    .rd_kind (rd_kind)
  );

  // pixel side, outputs two clocks behind scan
  tile_renderer u_render (
    .clk         (clk),
    .reset       (reset),
    .scan        (scan),
    .rd_kind     (rd_kind),
    .rd_col      (rd_col),
    .rd_row      (rd_row),
    .vga_r       (vga_r),
    .vga_g       (vga_g),
    .vga_b       (vga_b),
    .vga_clk     (vga_clk),
    .vga_hs      (vga_hs),
    .vga_vs      (vga_vs),
    .vga_blank_n (vga_blank_n)
  );

endmodule

`default_nettype wire

// File: tests/snake_display_tb.sv
// --------------------------------------------------------------------------
// snake display testbench
// bus write driver with a tile map reference model
// frame scanner rebuilding pixels from the VGA outputs alone
// sync shape, reset map, random, out-of-range and overwrite tests
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module snake_display_tb;

  // reference geometry and register map
  localparam int COLS         = 20;
  localparam int ROWS         = 15;
  localparam int LINE_CYCLES  = 1600;
  localparam int FRAME_CYCLES = LINE_CYCLES * 525;
  localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES;
  localparam logic [2:0] A_COL  = 3'd0;
  localparam logic [2:0] A_ROW  = 3'd1;
  localparam logic [2:0] A_KIND = 3'd2;

  logic       clk;
  logic       reset;
  logic [7:0] writedata;
  logic       write;
  logic       chipselect;
  logic [2:0] address;
  logic [7:0] vga_r;
  logic [7:0] vga_g;
  logic [7:0] vga_b;
  logic       vga_clk;
  logic       vga_hs;
  logic       vga_vs;
  logic       vga_blank_n;

  // model state, the tile kinds and the stored coordinates
  logic [2:0] model [COLS*ROWS];
  int         m_col;
  int         m_row;
  int         value_errors;
  int         other_errors;

  tb_clock u_clock (
    .clk   (clk),
    .reset (reset)
  );

  snake_display u_dut (
    .clk         (clk),
    .reset       (reset),
    .writedata   (writedata),
    .write       (write),
    .chipselect  (chipselect),
    .address     (address),
    .vga_r       (vga_r),
    .vga_g       (vga_g),
    .vga_b       (vga_b),
    .vga_clk     (vga_clk),
    .vga_hs      (vga_hs),
    .vga_vs      (vga_vs),
    .vga_blank_n (vga_blank_n)
  );

  // --------------------------------------------------------------------------
  // reference colours
  // --------------------------------------------------------------------------

  // RGB565 per kind, 5..7 are black like empty
  function automatic logic [15:0] tile_colour(input logic [2:0] kind);
    case (kind)
      3'd1:    return 16'h8410;
      3'd2:    return 16'hf800;
      3'd3:    return 16'hffe0;
      3'd4:    return 16'h07e0;
      default: return 16'h0000;
    endcase
  endfunction

  // zero padding on the right of each channel
  function automatic logic [23:0] widen(input logic [15:0] c);
    return {c[15:11], 3'b000, c[10:5], 2'b00, c[4:0], 3'b000};
  endfunction

  task automatic report_fault(input string msg);
    other_errors++;
    $display("at %0t ns: %s", $time, msg);
  endtask

  task automatic abort_run(input string msg);
    report_fault(msg);
    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    $display("Errors found");
    $finish;
  endtask

  // --------------------------------------------------------------------------
  // bus side, one write per two clocks, model follows each write
  // --------------------------------------------------------------------------
  task automatic bus_write(input logic [2:0] addr, input logic [7:0] data);
    @(negedge clk);
    chipselect = 1'b1;
    write      = 1'b1;
    address    = addr;
    writedata  = data;
    @(negedge clk);
    chipselect = 1'b0;
    write      = 1'b0;
    // column register keeps 5 bits, row register 4
    if (addr == A_COL) begin
      m_col = int'(data[4:0]);
    end else if (addr == A_ROW) begin
      m_row = int'(data[3:0]);
    end else if (addr == A_KIND && m_col < COLS && m_row < ROWS) begin
      model[m_row * COLS + m_col] = data[2:0];
    end
  endtask

  task automatic place_tile(input int col, input int row, input int kind);
    bus_write(A_COL, 8'(col));
    bus_write(A_ROW, 8'(row));
    bus_write(A_KIND, 8'(kind));
  endtask

  // waits for a vsync level, bounded by two frames
  task automatic wait_vs(input logic level);
    int n;
    n = 0;
    while (vga_vs !== level && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (vga_vs !== level) abort_run($sformatf("vga_vs never reached %0b", level));
  endtask

  task automatic confirm_in_vsync(input string what);
    assert (vga_vs == 1'b0) else report_fault({what, " ran past the vertical sync pulse"});
  endtask

  // --------------------------------------------------------------------------
  // frame scanner, one frame from a vsync rise to the next
  // --------------------------------------------------------------------------
  task automatic check_frame();
    int          line;
    int          lpos;
    int          x;
    int          hs_low;
    int          vs_low;
    int          blank_hi;
    logic        prev_blank;
    logic        prev_clk;
    logic [23:0] exp_rgb;
    wait_vs(1'b0);
    wait_vs(1'b1);
    line       = -1;
    lpos       = 0;
    hs_low     = 0;
    vs_low     = 0;
    blank_hi   = 0;
    prev_blank = 1'b0;
    prev_clk   = vga_clk;
    for (int cyc = 0; cyc < FRAME_CYCLES; cyc++) begin
      // a new line starts at each rising blank_n
      if (vga_blank_n && !prev_blank) begin
        line++;
        lpos = 0;
      end
      if (!vga_hs) hs_low++;
      if (!vga_vs) vs_low++;
      if (cyc > 0) begin
        assert (vga_clk != prev_clk) else report_fault("vga_clk did not toggle");
      end
      exp_rgb = 24'h0;
      if (vga_blank_n) begin
        x = lpos / 2;
        if (line < 480 && x < 640) begin
          exp_rgb = widen(tile_colour(model[(line >> 5) * COLS + (x >> 5)]));
        end
        blank_hi++;
        lpos++;
      end
      assert ({vga_r, vga_g, vga_b} === exp_rgb) else begin
        value_errors++;
        if (value_errors <= 10) begin
          $display("error at %0t ns: {vga_r,vga_g,vga_b} line %0d expected %06h, got %06h",
                   $time, line, exp_rgb, {vga_r, vga_g, vga_b});
        end
      end
      // blank_n just fell, line length check
      if (!vga_blank_n && prev_blank) begin
        assert (blank_hi == 1280)
          else report_fault($sformatf("vga_blank_n high for %0d cycles on a line", blank_hi));
        blank_hi = 0;
      end
      if (cyc % LINE_CYCLES == LINE_CYCLES - 1) begin
        assert (hs_low == 192)
          else report_fault($sformatf("vga_hs low for %0d cycles in a line", hs_low));
        hs_low = 0;
      end
      prev_blank = vga_blank_n;
      prev_clk   = vga_clk;
      @(negedge clk);
    end
    assert (line + 1 == 480) else report_fault($sformatf("frame had %0d lines", line + 1));
    assert (vs_low == 2 * LINE_CYCLES)
      else report_fault($sformatf("vga_vs low for %0d cycles in a frame", vs_low));
  endtask

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------
  initial begin
    int n;
    chipselect   = 1'b0;
    write        = 1'b0;
    address      = 3'd0;
    writedata    = 8'h00;
    value_errors = 0;
    other_errors = 0;
    m_col        = 0;
    m_row        = 0;
    for (int i = 0; i < COLS * ROWS; i++) begin
      model[i] = 3'd0;
    end
    void'($urandom(95));

    n = 0;
    while (reset && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (reset) abort_run("reset was never released");

    // sync shape plus an all black map
    check_frame();

    // random in-range tiles, every kind code
    wait_vs(1'b0);
    repeat (60) begin
      place_tile(int'($urandom_range(0, 19)), int'($urandom_range(0, 14)),
                 int'($urandom_range(0, 7)));
    end
    confirm_in_vsync("random tile writes");
    check_frame();

    // coordinates off the grid, only the low register bits count
    wait_vs(1'b0);
    repeat (20) begin
      if ($urandom_range(0, 1) == 1) begin
        place_tile(int'($urandom_range(20, 31)), int'($urandom_range(0, 14)),
                   int'($urandom_range(1, 4)));
      end else begin
        place_tile(int'($urandom_range(0, 19)), int'($urandom_range(15, 255)),
                   int'($urandom_range(1, 4)));
      end
    end
    confirm_in_vsync("out-of-range writes");
    check_frame();

    // kind rewrites on held coordinates, unused addresses ignored
    // last kind differs from the first so a lost rewrite shows
    wait_vs(1'b0);
    place_tile(int'($urandom_range(0, 19)), int'($urandom_range(0, 14)), 1);
    repeat (4) bus_write(A_KIND, 8'($urandom_range(0, 7)));
    for (int a = 3; a < 8; a++) begin
      bus_write(3'(a), 8'($urandom_range(0, 255)));
    end
    bus_write(A_KIND, 8'($urandom_range(2, 4)));
    confirm_in_vsync("overwrite sequence");
    check_frame();

    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// --------------------------------------------------------------------------
// testbench clock and reset generator
// 10 ns clock, reset held high for the first cycles
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic reset
);

  // free-running clock, low at time zero
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release on a falling edge, away from the DUT sampling edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: tiles/tile_map.sv
// --------------------------------------------------------------------------
// tile map, one kind per grid tile
// one synchronous write port, one registered read port
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tile_map (
  input  logic                                     clk,
  input  logic                                     reset,
  input  snake_display_pkg::tile_write_t           tile_wr,
  input  logic [snake_display_pkg::COL_W-1:0]      rd_col,
  input  logic [snake_display_pkg::ROW_W-1:0]      rd_row,
  output logic [snake_display_pkg::KIND_W-1:0]     rd_kind
);

  import snake_display_pkg::*;

  localparam int DEPTH  = GRID_COLS * GRID_ROWS;
  localparam int ADDR_W = $clog2(DEPTH);

  logic [KIND_W-1:0] kinds [DEPTH];
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr;
  logic              rd_in_grid;

  // row-major index
  assign wr_addr = ADDR_W'(tile_wr.row) * ADDR_W'(GRID_COLS) + ADDR_W'(tile_wr.col);
  assign rd_addr = ADDR_W'(rd_row) * ADDR_W'(GRID_COLS) + ADDR_W'(rd_col);

  // blanking reads can fall outside the grid
  assign rd_in_grid = (rd_col < COL_W'(GRID_COLS)) && (rd_row < ROW_W'(GRID_ROWS));

  // whole map starts empty
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        kinds[i] <= KIND_EMPTY;
      end
    end else if (tile_wr.valid) begin
      kinds[wr_addr] <= tile_wr.kind;
    end
  end

  // read data one cycle behind the address
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_kind <= KIND_EMPTY;
    end else begin
      rd_kind <= rd_in_grid ? kinds[rd_addr] : KIND_EMPTY;
    end
  end

  a_no_stray_write: assert property (@(posedge clk) disable iff (reset)
    tile_wr.valid |-> (tile_wr.col < COL_W'(GRID_COLS)) && (tile_wr.row < ROW_W'(GRID_ROWS)));

endmodule

`default_nettype wire

// File: tiles/tile_renderer.sv
// --------------------------------------------------------------------------
// tile renderer, two-stage pixel pipeline
// stage 1 tile address out, sync and active delayed
// stage 2 palette lookup, RGB565 widening, blanking
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tile_renderer (
  input  logic                                   clk,
  input  logic                                   reset,
  input  snake_display_pkg::scan_pos_t           scan,
  input  logic [snake_display_pkg::KIND_W-1:0]   rd_kind,
  output logic [snake_display_pkg::COL_W-1:0]    rd_col,
  output logic [snake_display_pkg::ROW_W-1:0]    rd_row,
  output logic [7:0]                             vga_r,
  output logic [7:0]                             vga_g,
  output logic [7:0]                             vga_b,
  output logic                                   vga_clk,
  output logic                                   vga_hs,
  output logic                                   vga_vs,
  output logic                                   vga_blank_n
);

  import snake_display_pkg::*;

  logic        s1_active;
  logic        s1_hs;
  logic        s1_vs;
  logic        s1_pix_clk;
  logic [15:0] pal;

  // --------------------------------------------------------------------------
  // stage 1
  // --------------------------------------------------------------------------

  // pixel column is hcount/2, so one extra shift
  assign rd_col = scan.hcount[TILE_SHIFT+1 +: COL_W];
  assign rd_row = scan.vcount[TILE_SHIFT +: ROW_W];

  // flags wait here while the map read is in flight
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      s1_active  <= 1'b0;
      s1_hs      <= 1'b0;
      s1_vs      <= 1'b0;
      s1_pix_clk <= 1'b0;
    end else begin
      s1_active  <= scan.active;
      s1_hs      <= scan.hs;
      s1_vs      <= scan.vs;
      s1_pix_clk <= scan.pix_clk;
    end
  end

  // --------------------------------------------------------------------------
  // stage 2
  // --------------------------------------------------------------------------

  // unknown kinds fall through to empty
  always_comb begin
    case (rd_kind)
      KIND_WALL:  pal = PAL_WALL;
      KIND_APPLE: pal = PAL_APPLE;
      KIND_HEAD:  pal = PAL_HEAD;
      KIND_BODY:  pal = PAL_BODY;
      default:    pal = PAL_EMPTY;
    endcase
  end

  // zero-pad each channel on the right, black when blanked
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vga_r       <= '0;
      vga_g       <= '0;
      vga_b       <= '0;
      vga_clk     <= 1'b0;
      vga_hs      <= 1'b0;
      vga_vs      <= 1'b0;
      vga_blank_n <= 1'b0;
    end else begin
      vga_r       <= s1_active ? {pal[15:11], 3'b000} : 8'h00;
      vga_g       <= s1_active ? {pal[10:5], 2'b00} : 8'h00;
      vga_b       <= s1_active ? {pal[4:0], 3'b000} : 8'h00;
      vga_clk     <= s1_pix_clk;
      vga_hs      <= s1_hs;
      vga_vs      <= s1_vs;
      vga_blank_n <= s1_active;
    end
  end

  a_black_in_blank: assert property (@(posedge clk) disable iff (reset)
    !vga_blank_n |-> ({vga_r, vga_g, vga_b} == 24'h0));

endmodule

`default_nettype wire

// File: vga/vga_timing.sv
// --------------------------------------------------------------------------
// VGA scan timing, 640 x 480 at one pixel every two clocks
// line and frame counters, sync and active decode
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
  parameter int H_ACTIVE = 1280,
  parameter int H_FRONT  = 32,
  parameter int H_SYNC   = 192,
  parameter int H_BACK   = 96,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic                   clk,
  input  logic                   reset,
  output snake_display_pkg::scan_pos_t scan
);

  import snake_display_pkg::*;

  // --------------------------------------------------------------------------
  // bounds derived from the timing parameters
  // --------------------------------------------------------------------------
  localparam logic [HCOUNT_W-1:0] H_LAST   = HCOUNT_W'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
  localparam logic [HCOUNT_W-1:0] H_VIS    = HCOUNT_W'(H_ACTIVE);
  localparam logic [HCOUNT_W-1:0] HS_START = HCOUNT_W'(H_ACTIVE + H_FRONT);
  localparam logic [HCOUNT_W-1:0] HS_END   = HCOUNT_W'(H_ACTIVE + H_FRONT + H_SYNC);
  localparam logic [VCOUNT_W-1:0] V_LAST   = VCOUNT_W'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);
  localparam logic [VCOUNT_W-1:0] V_VIS    = VCOUNT_W'(V_ACTIVE);
  localparam logic [VCOUNT_W-1:0] VS_START = VCOUNT_W'(V_ACTIVE + V_FRONT);
  localparam logic [VCOUNT_W-1:0] VS_END   = VCOUNT_W'(V_ACTIVE + V_FRONT + V_SYNC);

  logic [HCOUNT_W-1:0] hcount;
  logic [VCOUNT_W-1:0] vcount;
  logic                end_of_line;
  logic                end_of_frame;

  assign end_of_line  = (hcount == H_LAST);
  assign end_of_frame = (vcount == V_LAST);

  // pixel counter within a line
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hcount <= '0;
    end else if (end_of_line) begin
      hcount <= '0;
    end else begin
      hcount <= hcount + 1'b1;
    end
  end

  // line counter, steps once per line end
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vcount <= '0;
    end else if (end_of_line) begin
      vcount <= end_of_frame ? '0 : vcount + 1'b1;
    end
  end

  // sync pulses active low
  always_comb begin
    scan.hcount  = hcount;
    scan.vcount  = vcount;
    scan.active  = (hcount < H_VIS) && (vcount < V_VIS);
    scan.hs      = !((hcount >= HS_START) && (hcount < HS_END));
    scan.vs      = !((vcount >= VS_START) && (vcount < VS_END));
    scan.pix_clk = hcount[0];
  end

  // horizontal sync pulse must sit inside blanking
  a_hs_in_blank: assert property (@(posedge clk) disable iff (reset)
    scan.active |-> scan.hs);

endmodule

`default_nettype wire
